//--- design/bridge_pkg.sv
// shared widths, host register map and bus structs for the host-to-AXI4-Lite bridge
// every block refers to these by scoped name
`default_nettype none

package bridge_pkg;

  // sizes ------------------------------
  localparam int unsigned BYTECNT_W   = 2;
  localparam int unsigned REG_IDX_W   = 3;
  localparam int unsigned HOST_ADDR_W = REG_IDX_W + BYTECNT_W;
  localparam int unsigned CMD_DEPTH   = 4;
  // 64 words, byte addresses 0..255
  localparam int unsigned SRAM_WORDS  = 64;

  // plain vectors
  typedef logic [HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [7:0]             byte_t;
  typedef logic [31:0]            addr_t;
  typedef logic [31:0]            data_t;
  typedef logic [3:0]             strb_t;
  typedef logic [1:0]             resp_t;

  // register map -----------------------
  localparam logic [REG_IDX_W-1:0] REG_ADDR   = 3'd0;
  localparam logic [REG_IDX_W-1:0] REG_WDATA  = 3'd1;
  localparam logic [REG_IDX_W-1:0] REG_CMD    = 3'd2;
  localparam logic [REG_IDX_W-1:0] REG_STATUS = 3'd3;
  localparam logic [REG_IDX_W-1:0] REG_RDATA  = 3'd4;

  // command byte, strobe field in bits 7:4
  localparam int unsigned CMD_WRITE_BIT = 0;
  localparam int unsigned CMD_STRB_LSB  = 4;

  // status byte
  localparam int unsigned ST_BUSY   = 0;
  localparam int unsigned ST_FULL   = 1;
  localparam int unsigned ST_ERR    = 2;
  localparam int unsigned ST_RVALID = 3;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // structs ----------------------------
  typedef struct packed {
    logic  write;
    strb_t strb;
    addr_t addr;
    data_t wdata;
  } cmd_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } rsp_t;

  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } axil_req_t;

  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- design/host_regs.sv
// byte-wide host register file
// collects address and write data, pushes a command on the command byte write,
// and holds read data and status for the host to read back
`timescale 1ns/1ns
`default_nettype none

module host_regs (
  input  logic                   heep_clk,
  input  logic                   rst_n_i,
  input  bridge_pkg::host_addr_t host_addr_i,
  input  bridge_pkg::byte_t      host_wdata_i,
  input  logic                   host_wr_i,
  input  logic                   host_rd_i,
  output bridge_pkg::byte_t      host_rdata_o,
  input  logic                   fifo_full_i,
  input  logic                   fifo_empty_i,
  input  logic                   master_busy_i,
  input  bridge_pkg::rsp_t       rsp_i,
  output logic                   push_o,
  output bridge_pkg::cmd_t       cmd_o
);

  // buffer entries plus the one in the master
  localparam int unsigned PEND_W = $clog2(bridge_pkg::CMD_DEPTH + 2);

  logic [bridge_pkg::REG_IDX_W-1:0] reg_idx;
  logic [bridge_pkg::BYTECNT_W-1:0] byte_idx;
  logic                             cmd_wr;
  logic                             cmd_is_read;
  bridge_pkg::addr_t                addr_q;
  bridge_pkg::data_t                wdata_q;
  bridge_pkg::byte_t                cmd_q;
  bridge_pkg::data_t                rdata_q;
  bridge_pkg::byte_t                host_rdata_q;
  logic                             err_q;
  logic                             rvalid_q;
  // one bit per outstanding command, bit 0 oldest, 1 = read
  logic [bridge_pkg::CMD_DEPTH:0]   kind_q, kind_d;
  logic [PEND_W-1:0]                pend_q, pend_d;
  bridge_pkg::data_t                status_w;
  bridge_pkg::data_t                rd_word;

  assign reg_idx  = host_addr_i[bridge_pkg::HOST_ADDR_W-1:bridge_pkg::BYTECNT_W];
  assign byte_idx = host_addr_i[bridge_pkg::BYTECNT_W-1:0];

  // command fires on byte 0 of the command register
  assign cmd_wr      = host_wr_i && (reg_idx == bridge_pkg::REG_CMD) && (byte_idx == '0);
  assign cmd_is_read = !host_wdata_i[bridge_pkg::CMD_WRITE_BIT];
  assign push_o      = cmd_wr && !fifo_full_i;

  assign cmd_o.write = host_wdata_i[bridge_pkg::CMD_WRITE_BIT];
  assign cmd_o.strb  = host_wdata_i[bridge_pkg::CMD_STRB_LSB +: $bits(bridge_pkg::strb_t)];
  assign cmd_o.addr  = addr_q;
  assign cmd_o.wdata = wdata_q;

  // response kind tracking --------------
  always_comb begin
    kind_d = kind_q;
    pend_d = pend_q;
    if (rsp_i.valid) begin
      kind_d = kind_d >> 1;
      pend_d = pend_d - 1'b1;
    end
    if (push_o) begin
      kind_d[pend_d] = cmd_is_read;
      pend_d         = pend_d + 1'b1;
    end
  end

  // register writes ---------------------
  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q   <= '0;
      wdata_q  <= '0;
      cmd_q    <= '0;
      rdata_q  <= '0;
      err_q    <= 1'b0;
      rvalid_q <= 1'b0;
      kind_q   <= '0;
      pend_q   <= '0;
    end else begin
      kind_q <= kind_d;
      pend_q <= pend_d;
      if (host_wr_i && reg_idx == bridge_pkg::REG_ADDR)
        addr_q[byte_idx*8 +: 8] <= host_wdata_i;
      if (host_wr_i && reg_idx == bridge_pkg::REG_WDATA)
        wdata_q[byte_idx*8 +: 8] <= host_wdata_i;
      if (cmd_wr)
        cmd_q <= host_wdata_i;
      // host write-one-to-clear of the error flag
      if (host_wr_i && reg_idx == bridge_pkg::REG_STATUS && byte_idx == '0 &&
          host_wdata_i[bridge_pkg::ST_ERR])
        err_q <= 1'b0;
      // overflow or bus error, set wins over clear
      if ((cmd_wr && fifo_full_i) || (rsp_i.valid && rsp_i.err))
        err_q <= 1'b1;
      if (rsp_i.valid && kind_q[0]) begin
        rdata_q <= rsp_i.rdata;
        if (!rsp_i.err)
          rvalid_q <= 1'b1;
      end
      // new read makes the old data stale
      if (push_o && cmd_is_read)
        rvalid_q <= 1'b0;
    end
  end

  // status and read mux -----------------
  always_comb begin
    status_w                        = '0;
    status_w[bridge_pkg::ST_BUSY]   = !fifo_empty_i || master_busy_i;
    status_w[bridge_pkg::ST_FULL]   = fifo_full_i;
    status_w[bridge_pkg::ST_ERR]    = err_q;
    status_w[bridge_pkg::ST_RVALID] = rvalid_q;
    case (reg_idx)
      bridge_pkg::REG_ADDR:   rd_word = addr_q;
      bridge_pkg::REG_WDATA:  rd_word = wdata_q;
      bridge_pkg::REG_CMD:    rd_word = {24'd0, cmd_q};
      bridge_pkg::REG_STATUS: rd_word = status_w;
      bridge_pkg::REG_RDATA:  rd_word = rdata_q;
      default:                rd_word = '0;
    endcase
  end

  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      host_rdata_q <= '0;
    else if (host_rd_i)
      host_rdata_q <= rd_word[byte_idx*8 +: 8];
  end

  assign host_rdata_o = host_rdata_q;

  // host bus strobes are exclusive
  a_wr_rd_excl: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    !(host_wr_i && host_rd_i));

  // every response from the master matches a pushed command
  a_rsp_pending: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    rsp_i.valid |-> pend_q != '0);

endmodule

`default_nettype wire

//--- design/cmd_fifo.sv
// command buffer between the host registers and the bus master
// circular buffer, head entry shown while not empty, pop by the master
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo (
  input  logic             heep_clk,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  bridge_pkg::cmd_t cmd_i,
  input  logic             pop_i,
  output bridge_pkg::cmd_t head_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = $clog2(bridge_pkg::CMD_DEPTH);
  localparam int unsigned CNT_W = $clog2(bridge_pkg::CMD_DEPTH + 1);

  bridge_pkg::cmd_t mem_q [bridge_pkg::CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // entry storage
  always_ff @(posedge heep_clk) begin
    if (push_i)
      mem_q[wr_ptr_q] <= cmd_i;
  end

  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(bridge_pkg::CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(bridge_pkg::CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      // push and pop together leave the count
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(bridge_pkg::CMD_DEPTH));
  assign empty_o = (count_q == '0);

  a_no_push_full: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    full_o |-> !push_i);
  a_no_pop_empty: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    empty_o |-> !pop_i);

endmodule

`default_nettype wire

//--- design/axil_master.sv
// AXI4-Lite master, one buffered command at a time
// pops the head, runs a write or a read, then pulses a response to the host registers
`timescale 1ns/1ns
`default_nettype none

module axil_master (
  input  logic                  heep_clk,
  input  logic                  rst_n_i,
  input  bridge_pkg::cmd_t      head_i,
  input  logic                  empty_i,
  output logic                  pop_o,
  output bridge_pkg::axil_req_t axi_req_o,
  input  bridge_pkg::axil_rsp_t axi_rsp_i,
  output bridge_pkg::rsp_t      rsp_o,
  output logic                  busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WRITE_ADDR_DATA,
    WRITE_RESP,
    READ_ADDR,
    READ_DATA
  } state_e;

  state_e           state_q;
  bridge_pkg::cmd_t cmd_q;
  bridge_pkg::rsp_t rsp_q;
  // per-channel pending flags, aw and w may be taken apart
  logic             aw_pend_q;
  logic             w_pend_q;
  logic             aw_done;
  logic             w_done;

  assign pop_o   = (state_q == IDLE) && !empty_i;
  assign aw_done = axi_rsp_i.awready || !aw_pend_q;
  assign w_done  = axi_rsp_i.wready || !w_pend_q;

  // captured command
  always_ff @(posedge heep_clk) begin
    if (pop_o)
      cmd_q <= head_i;
  end

  // FSM --------------------------------
  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      rsp_q     <= '0;
    end else begin
      rsp_q.valid <= 1'b0;
      case (state_q)
        IDLE: begin
          if (!empty_i) begin
            if (head_i.write) begin
              state_q   <= WRITE_ADDR_DATA;
              aw_pend_q <= 1'b1;
              w_pend_q  <= 1'b1;
            end else begin
              state_q <= READ_ADDR;
            end
          end
        end
        WRITE_ADDR_DATA: begin
          if (axi_rsp_i.awready)
            aw_pend_q <= 1'b0;
          if (axi_rsp_i.wready)
            w_pend_q <= 1'b0;
          if (aw_done && w_done)
            state_q <= WRITE_RESP;
        end
        WRITE_RESP: begin
          if (axi_rsp_i.bvalid) begin
            state_q     <= IDLE;
            rsp_q.valid <= 1'b1;
            rsp_q.err   <= (axi_rsp_i.bresp != bridge_pkg::RESP_OKAY);
            rsp_q.rdata <= '0;
          end
        end
        READ_ADDR: begin
          if (axi_rsp_i.arready)
            state_q <= READ_DATA;
        end
        READ_DATA: begin
          if (axi_rsp_i.rvalid) begin
            state_q     <= IDLE;
            rsp_q.valid <= 1'b1;
            rsp_q.err   <= (axi_rsp_i.rresp != bridge_pkg::RESP_OKAY);
            rsp_q.rdata <= axi_rsp_i.rdata;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // bus drive --------------------------
  always_comb begin
    axi_req_o.awvalid = (state_q == WRITE_ADDR_DATA) && aw_pend_q;
    axi_req_o.awaddr  = cmd_q.addr;
    axi_req_o.wvalid  = (state_q == WRITE_ADDR_DATA) && w_pend_q;
    axi_req_o.wdata   = cmd_q.wdata;
    axi_req_o.wstrb   = cmd_q.strb;
    axi_req_o.bready  = 1'b1;
    axi_req_o.arvalid = (state_q == READ_ADDR);
    axi_req_o.araddr  = cmd_q.addr;
    axi_req_o.rready  = 1'b1;
  end

  assign rsp_o = rsp_q;
  // held through the response cycle so host flags are settled when busy drops
  assign busy_o = (state_q != IDLE) || rsp_q.valid;

  a_aw_stable: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    axi_req_o.awvalid && !axi_rsp_i.awready |=> $stable(axi_req_o.awaddr));
  a_w_stable: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    axi_req_o.wvalid && !axi_rsp_i.wready |=> $stable(axi_req_o.wdata));

endmodule

`default_nettype wire

//--- design/axil_sram.sv
// AXI4-Lite scratch memory standing in for the microcontroller memory
// fixed latency, byte strobes, SLVERR outside the word range
`timescale 1ns/1ns
`default_nettype none

module axil_sram (
  input  logic                  heep_clk,
  input  logic                  rst_n_i,
  input  bridge_pkg::axil_req_t axi_req_i,
  output bridge_pkg::axil_rsp_t axi_rsp_o
);

  localparam int unsigned IDX_W = $clog2(bridge_pkg::SRAM_WORDS);

  bridge_pkg::data_t mem_q [bridge_pkg::SRAM_WORDS];
  logic              aw_ack_q;
  logic              ar_ack_q;
  logic              bvalid_q;
  logic              rvalid_q;
  bridge_pkg::resp_t bresp_q;
  bridge_pkg::resp_t rresp_q;
  bridge_pkg::data_t rdata_q;
  logic              wr_fire;
  logic              rd_fire;
  logic              wr_in_range;
  logic              rd_in_range;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;

  // word addressing, low two bits dropped
  assign wr_idx      = axi_req_i.awaddr[2 +: IDX_W];
  assign rd_idx      = axi_req_i.araddr[2 +: IDX_W];
  assign wr_in_range = (axi_req_i.awaddr[31:2] < bridge_pkg::SRAM_WORDS);
  assign rd_in_range = (axi_req_i.araddr[31:2] < bridge_pkg::SRAM_WORDS);

  // handshake cycles
  assign wr_fire = aw_ack_q && axi_req_i.awvalid && axi_req_i.wvalid;
  assign rd_fire = ar_ack_q && axi_req_i.arvalid;

  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_ack_q <= 1'b0;
      ar_ack_q <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      bresp_q  <= bridge_pkg::RESP_OKAY;
      rresp_q  <= bridge_pkg::RESP_OKAY;
      rdata_q  <= '0;
      for (int i = 0; i < bridge_pkg::SRAM_WORDS; i++)
        mem_q[i] <= '0;
    end else begin
      // ready one cycle after both valids
      aw_ack_q <= axi_req_i.awvalid && axi_req_i.wvalid && !aw_ack_q && !bvalid_q;
      ar_ack_q <= axi_req_i.arvalid && !ar_ack_q && !rvalid_q;
      if (bvalid_q && axi_req_i.bready)
        bvalid_q <= 1'b0;
      if (rvalid_q && axi_req_i.rready)
        rvalid_q <= 1'b0;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_in_range ? bridge_pkg::RESP_OKAY : bridge_pkg::RESP_SLVERR;
        if (wr_in_range) begin
          for (int b = 0; b < $bits(bridge_pkg::strb_t); b++) begin
            if (axi_req_i.wstrb[b])
              mem_q[wr_idx][b*8 +: 8] <= axi_req_i.wdata[b*8 +: 8];
          end
        end
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_in_range ? bridge_pkg::RESP_OKAY : bridge_pkg::RESP_SLVERR;
        // out of range reads as zero
        rdata_q  <= rd_in_range ? mem_q[rd_idx] : '0;
      end
    end
  end

  always_comb begin
    axi_rsp_o.awready = aw_ack_q;
    axi_rsp_o.wready  = aw_ack_q;
    axi_rsp_o.bvalid  = bvalid_q;
    axi_rsp_o.bresp   = bresp_q;
    axi_rsp_o.arready = ar_ack_q;
    axi_rsp_o.rvalid  = rvalid_q;
    axi_rsp_o.rdata   = rdata_q;
    axi_rsp_o.rresp   = rresp_q;
  end

  // single outstanding transaction from the master
  a_b_r_excl: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    !(bvalid_q && rvalid_q));

endmodule

`default_nettype wire

//--- design/bridge_top.sv
// bridge top level
// host registers feed the command FIFO, the AXI4-Lite master drains it into the scratch memory
`timescale 1ns/1ns
`default_nettype none

module bridge_top (
  input  logic                   heep_clk,
  input  logic                   rst_n_i,
  input  bridge_pkg::host_addr_t host_addr_i,
  input  bridge_pkg::byte_t      host_wdata_i,
  input  logic                   host_wr_i,
  input  logic                   host_rd_i,
  output bridge_pkg::byte_t      host_rdata_o
);

  // producer to buffer
  logic                  push;
  bridge_pkg::cmd_t      cmd;
  logic                  fifo_full;
  logic                  fifo_empty;
  // buffer to consumer
  bridge_pkg::cmd_t      head;
  logic                  pop;
  // consumer back to producer
  bridge_pkg::rsp_t      rsp;
  logic                  master_busy;
  // AXI4-Lite channels
  bridge_pkg::axil_req_t axi_req;
  bridge_pkg::axil_rsp_t axi_rsp;

  host_regs u_host_regs (
    .heep_clk      (heep_clk),
    .rst_n_i       (rst_n_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_wr_i     (host_wr_i),
    .host_rd_i     (host_rd_i),
    .host_rdata_o  (host_rdata_o),
    .fifo_full_i   (fifo_full),
    .fifo_empty_i  (fifo_empty),
    .master_busy_i (master_busy),
    .rsp_i         (rsp),
    .push_o        (push),
    .cmd_o         (cmd)
  );

  cmd_fifo u_cmd_fifo (
    .heep_clk (heep_clk),
    .rst_n_i  (rst_n_i),
    .push_i   (push),
    .cmd_i    (cmd),
    .pop_i    (pop),
    .head_o   (head),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

  axil_master u_axil_master (
    .heep_clk  (heep_clk),
    .rst_n_i   (rst_n_i),
    .head_i    (head),
    .empty_i   (fifo_empty),
    .pop_o     (pop),
    .axi_req_o (axi_req),
    .axi_rsp_i (axi_rsp),
    .rsp_o     (rsp),
    .busy_o    (master_busy)
  );

  axil_sram u_axil_sram (
    .heep_clk  (heep_clk),
    .rst_n_i   (rst_n_i),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

endmodule

`default_nettype wire

//--- include/tb_host_tasks.svh
// host bus access tasks for the bridge testbench
// included inside tb_bridge and drives its host bus signals on the falling edge
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// byte access ------------------------

// holds one write strobe across the rising edge in between
task automatic put_byte(input bridge_pkg::host_addr_t addr, input bridge_pkg::byte_t data);
  @(negedge heep_clk);
  host_addr  = addr;
  host_wdata = data;
  host_wr    = 1'b1;
  @(negedge heep_clk);
  host_wr    = 1'b0;
endtask

// read data is registered and stable by the next falling edge
task automatic get_byte(input bridge_pkg::host_addr_t addr, output bridge_pkg::byte_t data);
  @(negedge heep_clk);
  host_addr = addr;
  host_rd   = 1'b1;
  @(negedge heep_clk);
  host_rd   = 1'b0;
  data      = host_rdata;
endtask

// word access ------------------------

// byte 0 first
task automatic put_word(input logic [bridge_pkg::REG_IDX_W-1:0] idx,
                        input bridge_pkg::data_t word);
  for (int b = 0; b < $bits(bridge_pkg::data_t) / 8; b++)
    put_byte({idx, 2'(b)}, word[b*8 +: 8]);
endtask

task automatic get_word(input logic [bridge_pkg::REG_IDX_W-1:0] idx,
                        output bridge_pkg::data_t word);
  bridge_pkg::byte_t bt;
  word = '0;
  for (int b = 0; b < $bits(bridge_pkg::data_t) / 8; b++) begin
    get_byte({idx, 2'(b)}, bt);
    word[b*8 +: 8] = bt;
  end
endtask

// status polling ---------------------

// returns the first status byte with busy low
task automatic wait_idle(output bridge_pkg::byte_t status);
  get_byte({bridge_pkg::REG_STATUS, 2'd0}, status);
  while (status[bridge_pkg::ST_BUSY])
    get_byte({bridge_pkg::REG_STATUS, 2'd0}, status);
endtask

`endif

//--- testbench/tb_bridge.sv
// testbench for the host-to-AXI4-Lite bridge
// replays testbench/bridge_trace.txt through the host registers and checks
// status and read data against a reference copy of the scratch memory
`timescale 1ns/1ns
`default_nettype none

module tb_bridge;

  // one parsed trace line
  typedef struct packed {
    logic [7:0]        kind;
    bridge_pkg::addr_t addr;
    bridge_pkg::data_t data;
    bridge_pkg::strb_t strb;
    logic              use_model;
    logic              err;
  } trace_op_t;

  logic                   heep_clk;
  logic                   rst_n;
  bridge_pkg::host_addr_t host_addr;
  bridge_pkg::byte_t      host_wdata;
  logic                   host_wr;
  logic                   host_rd;
  bridge_pkg::byte_t      host_rdata;

  // reference memory with the same strobe merge as the scratch memory
  bridge_pkg::data_t ref_mem [bridge_pkg::SRAM_WORDS];
  trace_op_t         ops [$];
  int                op_count;
  // expected read-valid flag carried between operations
  logic              rvalid_exp;

  bridge_top uut (
    .heep_clk     (heep_clk),
    .rst_n_i      (rst_n),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_wr_i    (host_wr),
    .host_rd_i    (host_rd),
    .host_rdata_o (host_rdata)
  );

  `include "tb_host_tasks.svh"

  // failure reporting ------------------
  task automatic stop_with_error(input string what);
    $display("Verification failed");
    $display("%s", what);
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input bridge_pkg::data_t got,
                             input bridge_pkg::data_t exp);
    assert (got === exp) else
      stop_with_error($sformatf("Mismatch at time %0t: %s got %h expected %h",
                                $time, name, got, exp));
  endtask

  // trace parsing ----------------------
  // comment lines start with #
  task automatic load_trace();
    int                fd;
    int                code;
    logic [7:0]        kind;
    logic [8*200-1:0]  rest;
    bridge_pkg::data_t f1, f2, f3, f4;
    trace_op_t         op;
    fd = $fopen("testbench/bridge_trace.txt", "r");
    if (fd == 0)
      stop_with_error("could not open testbench/bridge_trace.txt");
    code = $fscanf(fd, " %c", kind);
    while (code == 1) begin
      op      = '0;
      op.kind = kind;
      if (kind == "#") begin
        code = $fgets(rest, fd);
      end else if (kind == "W") begin
        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (code != 3)
          stop_with_error("write line in the trace file is malformed");
        op.addr = f1;
        op.data = f2;
        op.strb = f3[3:0];
        ops.push_back(op);
      end else if (kind == "R") begin
        code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
        if (code != 4)
          stop_with_error("read line in the trace file is malformed");
        op.addr      = f1;
        op.use_model = f2[0];
        op.data      = f3;
        op.err       = f4[0];
        ops.push_back(op);
      end else begin
        stop_with_error("trace file holds a line of unknown kind");
      end
      code = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);
  endtask

  // operations -------------------------
  task automatic check_reset_state();
    bridge_pkg::byte_t status;
    bridge_pkg::data_t got;
    get_byte({bridge_pkg::REG_STATUS, 2'd0}, status);
    check_equal("status after reset", {24'd0, status}, 32'd0);
    get_word(bridge_pkg::REG_RDATA, got);
    check_equal("REG_RDATA after reset", got, 32'd0);
  endtask

  task automatic apply_write(input trace_op_t op);
    bridge_pkg::data_t got;
    bridge_pkg::byte_t cmd_b;
    bridge_pkg::byte_t status;
    bridge_pkg::byte_t exp_status;
    put_word(bridge_pkg::REG_ADDR, op.addr);
    put_word(bridge_pkg::REG_WDATA, op.data);
    // staging registers read back as written
    get_word(bridge_pkg::REG_ADDR, got);
    check_equal("REG_ADDR", got, op.addr);
    get_word(bridge_pkg::REG_WDATA, got);
    check_equal("REG_WDATA", got, op.data);
    cmd_b                                = '0;
    cmd_b[bridge_pkg::CMD_WRITE_BIT]     = 1'b1;
    cmd_b[bridge_pkg::CMD_STRB_LSB +: 4] = op.strb;
    put_byte({bridge_pkg::REG_CMD, 2'd0}, cmd_b);
    wait_idle(status);
    // merge enabled bytes into the model
    if (op.addr < bridge_pkg::addr_t'(4 * bridge_pkg::SRAM_WORDS)) begin
      for (int b = 0; b < 4; b++) begin
        if (op.strb[b])
          ref_mem[op.addr[7:2]][b*8 +: 8] = op.data[b*8 +: 8];
      end
    end
    // a write leaves the read-valid flag alone
    exp_status                       = '0;
    exp_status[bridge_pkg::ST_RVALID] = rvalid_exp;
    check_equal("status after write", {24'd0, status}, {24'd0, exp_status});
  endtask

  task automatic apply_read(input trace_op_t op);
    bridge_pkg::data_t got;
    bridge_pkg::data_t exp_data;
    bridge_pkg::byte_t clr_b;
    bridge_pkg::byte_t status;
    bridge_pkg::byte_t exp_status;
    put_word(bridge_pkg::REG_ADDR, op.addr);
    // read command with the strobe field unused
    put_byte({bridge_pkg::REG_CMD, 2'd0}, 8'h00);
    wait_idle(status);
    exp_data                          = op.use_model ? ref_mem[op.addr[7:2]] : op.data;
    exp_status                        = '0;
    exp_status[bridge_pkg::ST_ERR]    = op.err;
    exp_status[bridge_pkg::ST_RVALID] = !op.err;
    check_equal("status after read", {24'd0, status}, {24'd0, exp_status});
    get_word(bridge_pkg::REG_RDATA, got);
    check_equal("REG_RDATA", got, exp_data);
    rvalid_exp = !op.err;
    if (op.err) begin
      // write one to clear the sticky flag
      clr_b                         = '0;
      clr_b[bridge_pkg::ST_ERR]     = 1'b1;
      put_byte({bridge_pkg::REG_STATUS, 2'd0}, clr_b);
      get_byte({bridge_pkg::REG_STATUS, 2'd0}, status);
      check_equal("status after error clear", {24'd0, status}, 32'd0);
    end
  endtask

  // clock, watchdog, replay ------------
  initial begin
    heep_clk = 1'b0;
    forever #20 heep_clk = ~heep_clk;
  end

  // budget of 200 cycles per trace operation
  initial begin
    wait (op_count != 0);
    repeat (op_count * 200) @(posedge heep_clk);
    stop_with_error("timeout, the trace replay did not finish in time");
  end

  initial begin
    rst_n      = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    rvalid_exp = 1'b0;
    for (int i = 0; i < bridge_pkg::SRAM_WORDS; i++)
      ref_mem[i] = '0;
    load_trace();
    if (ops.size() == 0)
      stop_with_error("trace file holds no operations");
    op_count = ops.size();
    // three rising edges in reset, release on the falling edge after them
    repeat (3) @(posedge heep_clk);
    @(negedge heep_clk);
    rst_n = 1'b1;
    check_reset_state();
    foreach (ops[i]) begin
      if (ops[i].kind == "W")
        apply_write(ops[i]);
      else
        apply_read(ops[i]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/bridge_trace.txt
# W <addr> <wdata> <strb>           write, strobe is one hex digit
# R <addr> <src> <value> <err>      src 1 takes the reference model, 0 the literal value
# full-strobe words, then read back
W 00000000 11223344 f
R 00000000 1 00000000 0
W 00000004 deadbeef f
R 00000004 0 deadbeef 0
# partial strobes merge into the stored word
W 00000004 a5a5a5a5 5
R 00000004 0 dea5bea5 0
W 00000004 00c30000 4
R 00000004 1 00000000 0
W 000000fc cafef00d f
W 000000fc 00000012 1
R 000000fc 0 cafef012 0
W 00000080 87654321 c
R 00000080 0 87650000 0
# words never written read as zero
R 00000040 0 00000000 0
R 000000f8 1 00000000 0
# past the end of the memory
R 00000100 0 00000000 1
R 0000fffc 0 00000000 1
# traffic after the error was cleared
W 00000010 0badf00d 3
R 00000010 1 00000000 0
W 00000010 ffffffff 8
R 00000010 0 ff00f00d 0
R 00000000 1 00000000 0

//--- src.f
+incdir+include
design/bridge_pkg.sv
design/host_regs.sv
design/cmd_fifo.sv
design/axil_master.sv
design/axil_sram.sv
design/bridge_top.sv
testbench/tb_bridge.sv

//--- run_sim.sh
#!/bin/sh
# builds the bridge testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module tb_bridge -f src.f &&
  ./obj_dir/Vtb_bridge || exit 1
